// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_rv_mult_unit
FILELIST  := all.f
VFLAGS    := --binary --timing -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+include
verilog/rv_arch_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/rv_csa.sv
verilog/rv_csa_tree_8.sv
verilog/rv_simd_mult.sv
verilog/rv_res_fifo.sv
verilog/rv_credit_counter.sv
verilog/rv_res_send_fsm.sv
verilog/rv_mult_unit.sv
sim/tb_clk_gen.sv
sim/tb_rv_mult_unit.sv

// ==== include/rv_mult_macros.svh ====
`ifndef RV_MULT_MACROS_SVH
`define RV_MULT_MACROS_SVH

// operand width of the execute stage
`define MULT_ARCH_WIDTH 32

// result buffer slots, also the upstream credits after reset
`define MULT_RES_DEPTH 4

// downstream credit count saturates here
`define MULT_CREDIT_MAX 7

// walk a bit index over a width
`define MULT_IT(idx, width) for (int idx = 0; idx < (width); idx++)

`endif

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic o_clk
);

initial begin
    o_clk = 1'b0;
    forever begin
        #(PERIOD_NS / 2.0) o_clk = ~o_clk; // half period per toggle
    end
end

endmodule

`default_nettype wire

// ==== sim/tb_rv_mult_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mult_macros.svh"

module tb_rv_mult_unit;

localparam int DEPTH = `MULT_RES_DEPTH;
localparam int CREDIT_MAX = `MULT_CREDIT_MAX;
localparam int WAIT_LIMIT = 2000; // cycles per wait loop
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic clk;
logic rst;
logic in_valid;
rv_arch_pkg::mult_op_t in_op;
rv_arch_pkg::simd_t in_a;
rv_arch_pkg::simd_t in_b;
logic res_credit;
logic up_credit;
logic res_valid;
rv_arch_pkg::simd_t res;

logic [31:0] lfsr;
logic [31:0] exp_q[$]; // expected results in issue order
int up_credits; // issuer side credits held
int dn_credits; // grants not yet spent by a send
int model_buf; // results the buffer should hold this cycle
int model_cnt; // downstream count the unit should hold this cycle
logic model_stage; // operation in the multiply stage this cycle
logic send_due; // o_res_valid and o_credit expected this cycle
int issued;
int delivered;
int credit_pulses;
int errors;
int timeouts;

tb_clk_gen #(.PERIOD_NS(8.0)) u_clk_gen (.o_clk(clk));

rv_mult_unit rv_mult_unit_inst (
    .clk          (clk),
    .i_rst        (rst),
    .i_valid      (in_valid),
    .i_op         (in_op),
    .i_a          (in_a),
    .i_b          (in_b),
    .i_res_credit (res_credit),
    .o_credit     (up_credit),
    .o_res_valid  (res_valid),
    .o_res        (res)
);

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
endfunction

// one step per bit with the lsb filled first
task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
        lfsr = lfsr_next(lfsr);
        v[k] = lfsr[0];
    end
endtask

// mostly random words and now and then a sign extreme or lane corner
task automatic pick_operand(output logic [31:0] v);
    logic [31:0] kind;
    logic [31:0] idx;
    draw_bits(2, kind);
    if (kind == 32'd0) begin
        draw_bits(3, idx);
        case (idx[2:0])
            3'd0: v = 32'h8000_0000;
            3'd1: v = 32'h7fff_ffff;
            3'd2: v = 32'hffff_ffff;
            3'd3: v = 32'h0000_0000;
            3'd4: v = 32'h8000_8000; // both 16-bit lanes at minimum
            3'd5: v = 32'h8080_8080; // all byte lanes at minimum
            3'd6: v = 32'h7fff_7fff;
            3'd7: v = 32'h0000_0001;
        endcase
    end else begin
        draw_bits(32, v);
    end
endtask

// reference from the arithmetic rules of each operation
function automatic logic [31:0] model_result(input rv_arch_pkg::mult_op_t op,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] prod;
    logic signed [63:0] dot;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'h0, a};
    ub = {32'h0, b};
    dot = '0;
    case (op)
        rv_arch_pkg::MULT_OP_MUL: begin
            prod = sa * sb;
            return prod[31:0];
        end
        rv_arch_pkg::MULT_OP_MULH: begin
            prod = sa * sb;
            return prod[63:32];
        end
        rv_arch_pkg::MULT_OP_MULHSU: begin
            prod = sa * ub; // signed a against unsigned b
            return prod[63:32];
        end
        rv_arch_pkg::MULT_OP_MULHU: begin
            prod = ua * ub;
            return prod[63:32];
        end
        rv_arch_pkg::MULT_OP_DOT16: begin
            for (int l = 0; l < 2; l++) begin
                dot = dot + $signed(a[16*l +: 16]) * $signed(b[16*l +: 16]);
            end
            return dot[31:0];
        end
        rv_arch_pkg::MULT_OP_DOT8: begin
            for (int l = 0; l < 4; l++) begin
                dot = dot + $signed(a[8*l +: 8]) * $signed(b[8*l +: 8]);
            end
            return {{15{dot[16]}}, dot[16:0]}; // 17-bit sum sign extended
        end
        default: return 32'h0;
    endcase
endfunction

task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
        errors++;
        $display("ERROR at %0d ns: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

// outputs are registered, so they are steady at the falling edge
task automatic observe_outputs();
    logic [31:0] expected;
    compare_value(32'(res_valid), 32'(send_due), "o_res_valid against the send timing");
    compare_value(32'(up_credit), 32'(send_due), "o_credit against the send timing");
    if (res_valid) begin
        if (dn_credits == 0) begin
            errors++;
            $display("a result was sent at %0d ns without an unused downstream credit",
                     $time);
        end else begin
            dn_credits--;
        end
        if (exp_q.size() == 0) begin
            errors++;
            $display("a result was sent at %0d ns with no operation outstanding", $time);
        end else begin
            expected = exp_q.pop_front();
            compare_value(res, expected, $sformatf("result %0d", delivered));
        end
        delivered++;
    end
    if (up_credit) begin
        credit_pulses++;
        up_credits++;
    end
endtask

// modes are 0 for never, 1 for random and 2 for whenever allowed
task automatic drive_inputs(input int issue_mode, input int grant_mode);
    logic [31:0] coin;
    logic [31:0] op_sel;
    logic [31:0] a;
    logic [31:0] b;
    rv_arch_pkg::mult_op_t op;
    in_valid = 1'b0;
    res_credit = 1'b0;
    draw_bits(1, coin);
    if (up_credits > 0 && (issue_mode == 2 || (issue_mode == 1 && coin[0]))) begin
        draw_bits(3, op_sel);
        op = rv_arch_pkg::mult_op_t'(3'(op_sel % 6));
        pick_operand(a);
        pick_operand(b);
        in_valid = 1'b1;
        in_op = op;
        in_a = a;
        in_b = b;
        exp_q.push_back(model_result(op, a, b));
        up_credits--;
        issued++;
    end
    draw_bits(2, coin);
    // keep the unit's counter below saturation
    if (dn_credits < CREDIT_MAX &&
        (grant_mode == 2 || (grant_mode == 1 && coin[1:0] != 2'd0))) begin
        res_credit = 1'b1;
        dn_credits++;
    end
endtask

// one clock edge of buffer, credit count and send timing
task automatic step_send_model();
    logic pop_now;
    pop_now = (model_buf > 0) && (model_cnt > 0);
    model_buf = model_buf + int'(model_stage) - int'(pop_now);
    model_cnt = model_cnt + int'(res_credit) - int'(pop_now);
    model_stage = in_valid; // result written one edge later
    send_due = pop_now;
endtask

task automatic run_cycle(input int issue_mode, input int grant_mode);
    @(negedge clk);
    observe_outputs();
    drive_inputs(issue_mode, grant_mode);
    step_send_model();
endtask

// issue without grants until both credit pools are dry
task automatic wait_backpressure();
    int n;
    n = 0;
    while ((up_credits != 0 || dn_credits != 0) && n < WAIT_LIMIT) begin
        run_cycle(2, 0);
        n++;
    end
    if (up_credits != 0 || dn_credits != 0) begin
        timeouts++;
        $display("timed out after %0d cycles waiting for the issuer to run out of credits", n);
    end
endtask

task automatic drain(input int grant_mode, input string phase);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || up_credits != DEPTH) && n < WAIT_LIMIT) begin
        run_cycle(0, grant_mode);
        n++;
    end
    if (exp_q.size() != 0 || up_credits != DEPTH) begin
        timeouts++;
        $display("timed out after %0d cycles draining results in the %s phase", n, phase);
    end
endtask

initial begin
    int held;
    lfsr = 32'd63;
    rst = 1'b1;
    in_valid = 1'b0;
    in_op = rv_arch_pkg::MULT_OP_MUL;
    in_a = '0;
    in_b = '0;
    res_credit = 1'b0;
    up_credits = DEPTH;
    dn_credits = 0;
    model_buf = 0;
    model_cnt = 0;
    model_stage = 1'b0;
    send_due = 1'b0;
    issued = 0;
    delivered = 0;
    credit_pulses = 0;
    errors = 0;
    timeouts = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // nothing issued or granted
    for (int c = 0; c < 8; c++) begin
        run_cycle(0, 0);
        compare_value(32'(res_valid), 32'd0, "o_res_valid high while idle after reset");
        compare_value(32'(up_credit), 32'd0, "o_credit high while idle after reset");
    end

    // work exists but no credit yet
    for (int c = 0; c < 10; c++) begin
        run_cycle(2, 0);
        compare_value(32'(res_valid), 32'd0, "o_res_valid high before any grant");
    end

    for (int c = 0; c < 400; c++) begin
        run_cycle(1, 1);
    end
    drain(2, "random mix");

    if (timeouts == 0) begin
        for (int c = 0; c < 200; c++) begin
            run_cycle(2, 2); // back-to-back issue
        end
        drain(2, "back-to-back");
    end

    if (timeouts == 0) begin
        wait_backpressure();
        held = delivered;
        for (int c = 0; c < 20; c++) begin
            run_cycle(0, 0);
        end
        compare_value(delivered, held, "results sent while grants were withheld");
        compare_value(exp_q.size(), DEPTH, "results waiting in the buffer");
        compare_value(up_credits, 0, "upstream credits left under back-pressure");
        drain(1, "back-pressure release");
    end

    compare_value(credit_pulses, delivered, "o_credit pulses against results delivered");
    compare_value(delivered, issued, "results delivered against operations issued");

    $display("delivered %0d of %0d issued, %0d errors, %0d timeouts",
             delivered, issued, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== verilog/rv_arch_pkg.sv ====
`default_nettype none

`include "rv_mult_macros.svh"

package rv_arch_pkg;

typedef logic [`MULT_ARCH_WIDTH-1:0] simd_t; // operand / result word
typedef logic [2*`MULT_ARCH_WIDTH-1:0] simd_d_t; // pp rows and tree sums

// bit 2 set for the packed dot products
typedef enum logic [2:0] {
    MULT_OP_MUL    = 3'd0,
    MULT_OP_MULH   = 3'd1,
    MULT_OP_MULHSU = 3'd2,
    MULT_OP_MULHU  = 3'd3,
    MULT_OP_DOT16  = 3'd4,
    MULT_OP_DOT8   = 3'd5
} mult_op_t;

endpackage

`default_nettype wire

// ==== verilog/rv_credit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mult_macros.svh"

module rv_credit_counter #(
    parameter int MAX = `MULT_CREDIT_MAX
) (
    input  logic clk,
    input  logic i_rst,
    input  logic i_inc,
    input  logic i_dec,
    output logic o_avail
);

rv_ctrl_pkg::credit_cnt_t cnt;

always_ff @(posedge clk) begin
    if (i_rst) begin
        cnt <= '0;
    end else if (i_inc && !i_dec) begin
        // grants beyond MAX are dropped
        if (cnt != rv_ctrl_pkg::credit_cnt_t'(MAX)) begin
            cnt <= cnt + 1'b1;
        end
    end else if (i_dec && !i_inc) begin
        cnt <= cnt - 1'b1; // only spent while nonzero
    end
end

assign o_avail = (cnt != '0);

endmodule

`default_nettype wire

// ==== verilog/rv_csa.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_csa #(
    parameter int W = 64
) (
    input  logic [W-1:0] i_x,
    input  logic [W-1:0] i_y,
    input  logic [W-1:0] i_z,
    output logic [W-1:0] o_s,
    output logic [W-1:0] o_c
);

// full adder per bit, carry left unshifted
assign o_s = i_x ^ i_y ^ i_z;
assign o_c = (i_x & i_y) | (i_x & i_z) | (i_y & i_z);

endmodule

`default_nettype wire

// ==== verilog/rv_csa_tree_8.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_csa_tree_8 #(
    parameter int W = 64
) (
    input  logic [7:0][W-1:0] i_a,
    output logic [1:0][W-1:0] o_o
);

logic [W-1:0] s0, c0, s1, c1, s2, c2, s3, c3, s4, c4, s5, c5;

// 8 -> 6 rows
rv_csa #(.W(W)) u_csa_0 (.i_x(i_a[0]), .i_y(i_a[1]), .i_z(i_a[2]), .o_s(s0), .o_c(c0));
rv_csa #(.W(W)) u_csa_1 (.i_x(i_a[3]), .i_y(i_a[4]), .i_z(i_a[5]), .o_s(s1), .o_c(c1));

// 6 -> 4 rows, i_a[6] and i_a[7] join here
rv_csa #(.W(W)) u_csa_2 (.i_x(s0), .i_y(c0 << 1), .i_z(s1), .o_s(s2), .o_c(c2));
rv_csa #(.W(W)) u_csa_3 (.i_x(c1 << 1), .i_y(i_a[6]), .i_z(i_a[7]), .o_s(s3), .o_c(c3));

// 4 -> 3 -> 2
rv_csa #(.W(W)) u_csa_4 (.i_x(s2), .i_y(c2 << 1), .i_z(s3), .o_s(s4), .o_c(c4));
rv_csa #(.W(W)) u_csa_5 (.i_x(s4), .i_y(c4 << 1), .i_z(c3 << 1), .o_s(s5), .o_c(c5));

assign o_o[0] = s5;
assign o_o[1] = c5 << 1; // carry leaves already aligned

endmodule

`default_nettype wire

// ==== verilog/rv_ctrl_pkg.sv ====
`default_nettype none

`include "rv_mult_macros.svh"

package rv_ctrl_pkg;

typedef logic [$clog2(`MULT_CREDIT_MAX+1)-1:0] credit_cnt_t;
typedef logic [$clog2(`MULT_RES_DEPTH):0] fifo_ptr_t; // msb is the wrap bit

typedef enum logic [1:0] {
    IDLE    = 2'd0, // nothing buffered
    SEND    = 2'd1, // result going out this cycle
    STARVED = 2'd2  // data waiting on downstream credit
} send_state_t;

endpackage

`default_nettype wire

// ==== verilog/rv_mult_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mult_macros.svh"

module rv_mult_unit (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_valid,
    input  rv_arch_pkg::mult_op_t i_op,
    input  rv_arch_pkg::simd_t    i_a,
    input  rv_arch_pkg::simd_t    i_b,
    input  logic                  i_res_credit,
    output logic                  o_credit,
    output logic                  o_res_valid,
    output rv_arch_pkg::simd_t    o_res
);

logic mult_valid;
rv_arch_pkg::simd_t mult_p;
rv_arch_pkg::simd_t fifo_rdata;
logic fifo_empty;
logic pop;
logic credit_avail;

rv_simd_mult u_simd_mult (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_en    (i_valid), // issue drives the stage
    .i_op    (i_op),
    .i_a     (i_a),
    .i_b     (i_b),
    .o_valid (mult_valid),
    .o_p     (mult_p)
);

rv_res_fifo #(.DEPTH(`MULT_RES_DEPTH)) u_res_fifo (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_wr    (mult_valid),
    .i_wdata (mult_p),
    .i_rd    (pop),
    .o_rdata (fifo_rdata),
    .o_empty (fifo_empty)
);

rv_credit_counter #(.MAX(`MULT_CREDIT_MAX)) u_credit_counter (
    .clk     (clk),
    .i_rst   (i_rst),
    .i_inc   (i_res_credit),
    .i_dec   (pop),
    .o_avail (credit_avail)
);

rv_res_send_fsm u_res_send_fsm (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_empty     (fifo_empty),
    .i_avail     (credit_avail),
    .o_pop       (pop),
    .o_res_valid (o_res_valid)
);

// head word taken together with the pop
always_ff @(posedge clk) begin
    if (pop) begin
        o_res <= fifo_rdata;
    end
end

assign o_credit = o_res_valid; // registered pop, slot handed back upstream

endmodule

`default_nettype wire

// ==== verilog/rv_res_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mult_macros.svh"

module rv_res_fifo #(
    parameter int DEPTH = `MULT_RES_DEPTH
) (
    input  logic               clk,
    input  logic               i_rst,
    input  logic               i_wr,
    input  rv_arch_pkg::simd_t i_wdata,
    input  logic               i_rd,
    output rv_arch_pkg::simd_t o_rdata,
    output logic               o_empty
);

localparam int IW = $clog2(DEPTH); // index bits below the wrap bit

rv_arch_pkg::simd_t mem [DEPTH];
rv_ctrl_pkg::fifo_ptr_t wr_ptr, rd_ptr;

always_ff @(posedge clk) begin
    if (i_rst) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
    end else begin
        if (i_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (i_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (i_wr) begin
        mem[wr_ptr[IW-1:0]] <= i_wdata;
    end
end

assign o_empty = (wr_ptr == rd_ptr); // wrap bits equal too
assign o_rdata = mem[rd_ptr[IW-1:0]]; // head word always showing

endmodule

`default_nettype wire

// ==== verilog/rv_res_send_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_res_send_fsm (
    input  logic clk,
    input  logic i_rst,
    input  logic i_empty,
    input  logic i_avail,
    output logic o_pop,
    output logic o_res_valid
);

rv_ctrl_pkg::send_state_t state, state_nxt;

// one result per cycle while data and credit are both there
assign o_pop = !i_empty && i_avail;

always_comb begin
    if (i_empty) begin
        state_nxt = rv_ctrl_pkg::IDLE;
    end else if (i_avail) begin
        state_nxt = rv_ctrl_pkg::SEND;
    end else begin
        state_nxt = rv_ctrl_pkg::STARVED; // head word waits for a grant
    end
end

always_ff @(posedge clk) begin
    if (i_rst) begin
        state <= rv_ctrl_pkg::IDLE;
    end else begin
        state <= state_nxt;
    end
end

// SEND is entered exactly on a pop, so this is the pop one cycle later
assign o_res_valid = (state == rv_ctrl_pkg::SEND);

endmodule

`default_nettype wire

// ==== verilog/rv_simd_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_mult_macros.svh"

module rv_simd_mult (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic                  i_en,
    input  rv_arch_pkg::mult_op_t i_op,
    input  rv_arch_pkg::simd_t    i_a,
    input  rv_arch_pkg::simd_t    i_b,
    output logic                  o_valid,
    output rv_arch_pkg::simd_t    o_p
);

localparam int W = `MULT_ARCH_WIDTH;
localparam int WD = 2 * W;
localparam int CORR_DOT16 = W / 2 + 1; // 2^16 from each of two lanes
localparam int CORR_DOT8 = W / 4 + 2; // 2^8 from each of four lanes
localparam int DOT8_W = W / 2 + 1; // dot8 result bits
localparam int DOT8_PAD = W - DOT8_W;

// baugh-wooley: invert sign row / sign col, but not sign x sign
function automatic logic bw_flip(input int i, input int j, input int l);
    return ((i % l) == (l - 1)) != ((j % l) == (l - 1));
endfunction

// row and column on the same diagonal tile
function automatic logic tile_hit(input int i, input int j, input int l);
    return (i / l) == (j / l);
endfunction

logic op_dot16, op_dot8, op_mulhu;
assign op_dot16 = (i_op == rv_arch_pkg::MULT_OP_DOT16);
assign op_dot8 = (i_op == rv_arch_pkg::MULT_OP_DOT8);
assign op_mulhu = (i_op == rv_arch_pkg::MULT_OP_MULHU);

// AND matrix, row i is a[i] against all of b
rv_arch_pkg::simd_t [W-1:0] pp;
always_comb begin
    `MULT_IT(i, W) begin
        `MULT_IT(j, W) begin
            if (op_dot8) begin
                pp[i][j] = tile_hit(i, j, 8) & ((i_a[i] & i_b[j]) ^ bw_flip(i, j, 8));
            end else if (op_dot16) begin
                pp[i][j] = tile_hit(i, j, 16) & ((i_a[i] & i_b[j]) ^ bw_flip(i, j, 16));
            end else if (op_mulhu) begin
                pp[i][j] = i_a[i] & i_b[j]; // plain unsigned
            end else begin
                pp[i][j] = (i_a[i] & i_b[j]) ^ bw_flip(i, j, W);
            end
        end
    end
end

// rows shifted into place, packed lanes pulled back down to bit 0
rv_arch_pkg::simd_d_t [W-1:0] ppv;
always_comb begin
    `MULT_IT(i, W) begin
        if (op_dot8) begin
            ppv[i] = (rv_arch_pkg::simd_d_t'(pp[i]) << (i % 8)) >> ((i / 8) * 8);
        end else if (op_dot16) begin
            ppv[i] = (rv_arch_pkg::simd_d_t'(pp[i]) << (i % 16)) >> ((i / 16) * 16);
        end else begin
            ppv[i] = rv_arch_pkg::simd_d_t'(pp[i]) << i;
        end
    end
end

// correction constant of the modified BW form
rv_arch_pkg::simd_d_t corr;
always_comb begin
    corr = '0;
    if (op_dot8) begin
        corr[CORR_DOT8] = 1'b1; // the 2^15 terms overflow out of 17 bits
    end else if (op_dot16) begin
        corr[CORR_DOT16] = 1'b1;
    end else begin
        corr[W] = 1'b1;
        corr[WD-1] = 1'b1;
    end
end

// first level, four trees side by side
rv_arch_pkg::simd_d_t [3:0][1:0] tree_o;
for (genvar t = 0; t < 4; t++) begin : g_tree
    rv_csa_tree_8 #(.W(WD)) u_tree (
        .i_a (ppv[8*t +: 8]),
        .o_o (tree_o[t])
    );
end

// stage register
rv_arch_pkg::simd_d_t [3:0][1:0] tree_q;
rv_arch_pkg::simd_d_t corr_q;
rv_arch_pkg::simd_t a_q;
rv_arch_pkg::mult_op_t op_q;
logic b_sign_q;
logic valid_q;

always_ff @(posedge clk) begin
    if (i_rst) begin
        valid_q <= 1'b0;
        op_q <= rv_arch_pkg::MULT_OP_MUL;
    end else begin
        valid_q <= i_en;
        if (i_en) begin
            op_q <= i_op;
        end
    end
end

always_ff @(posedge clk) begin
    if (i_en) begin
        tree_q <= tree_o;
        corr_q <= corr;
        a_q <= i_a;
        b_sign_q <= i_b[W-1];
    end
end

// final tree over the eight registered rows
rv_arch_pkg::simd_d_t [1:0] tree_f;
rv_csa_tree_8 #(.W(WD)) u_tree_f (
    .i_a (tree_q),
    .o_o (tree_f)
);

rv_arch_pkg::simd_d_t sum_u; // no correction, unsigned product
assign sum_u = tree_f[0] + tree_f[1];

// fold in the correction
rv_arch_pkg::simd_d_t s_corr, c_corr, c_corr_al, mul_s;
rv_csa #(.W(WD)) u_csa_corr (
    .i_x (tree_f[0]),
    .i_y (tree_f[1]),
    .i_z (corr_q),
    .o_s (s_corr),
    .o_c (c_corr)
);
assign c_corr_al = c_corr << 1;
assign mul_s = s_corr + c_corr_al;

// b was taken as signed, add a * 2^32 back when its msb is set
rv_arch_pkg::simd_d_t s_hsu, c_hsu, mul_hsu;
rv_csa #(.W(WD)) u_csa_hsu (
    .i_x (s_corr),
    .i_y (c_corr_al),
    .i_z ({a_q, {W{1'b0}}}),
    .o_s (s_hsu),
    .o_c (c_hsu)
);
assign mul_hsu = s_hsu + (c_hsu << 1);

always_comb begin
    case (op_q)
        rv_arch_pkg::MULT_OP_MUL: o_p = mul_s[W-1:0];
        rv_arch_pkg::MULT_OP_MULH: o_p = mul_s[WD-1:W];
        rv_arch_pkg::MULT_OP_MULHSU: o_p = b_sign_q ? mul_hsu[WD-1:W] : mul_s[WD-1:W];
        rv_arch_pkg::MULT_OP_MULHU: o_p = sum_u[WD-1:W];
        rv_arch_pkg::MULT_OP_DOT16: o_p = mul_s[W-1:0];
        rv_arch_pkg::MULT_OP_DOT8: o_p = {{DOT8_PAD{mul_s[DOT8_W-1]}}, mul_s[DOT8_W-1:0]};
        default: o_p = '0;
    endcase
end

assign o_valid = valid_q;

endmodule

`default_nettype wire
